/* files.f */
+incdir+source
source/fmap_pkg.sv
source/fmap_lane_mask.sv
source/fmap_bank.sv
source/fmap_pingpong.sv
source/fmap_buffer_top.sv
sim/tb_fmap_buffer.sv

/* sim/tb_fmap_buffer.sv */
// testbench for the feature-map buffer: clock, reset, LCG stimulus, reference model and checks
`timescale 1ns/1ns
`include "fmap_params.svh"

module tb_fmap_buffer;

    localparam int DEPTH        = 1 << `FMAP_ADDR_W;
    // planned stimulus length in cycles, rounded up
    localparam int STIM_CYCLES  = 200;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + 100;
    localparam int ROUND_TRIP_N = 16;
    localparam int PP_N         = 8;
    localparam int FC_N         = 4;

    logic                 clk_cal;
    logic                 rst_cal_n;
    fmap_pkg::layer_t     nn_layer_cnt;
    fmap_pkg::span_t      omap_addr_span_cnt;
    fmap_pkg::fmap_addr_t wr_addr;
    logic                 conv_vld;
    fmap_pkg::lane_vec_t  conv_data;
    logic                 fc_vld;
    fmap_pkg::lane_vec_t  fc_data;
    logic                 rd_en;
    fmap_pkg::fmap_addr_t rd_addr;
    logic                 out_vld;
    fmap_pkg::lane_vec_t  out_data;

    // reference model state
    fmap_pkg::lane_vec_t  model_mem [0:1][0:DEPTH-1];
    fmap_pkg::lane_vec_t  exp_q [$];
    fmap_pkg::layer_t     cur_layer;
    fmap_pkg::span_t      cur_span;
    logic [31:0]          lcg_state;
    logic                 vld_d1;
    logic                 vld_d2;
    logic                 seen_read;
    fmap_pkg::lane_vec_t  mon_exp;
    int                   check_cnt;
    int                   mismatch_cnt;
    int                   other_err_cnt;
    int                   cycle_cnt;

    fmap_buffer_top u_dut (
        .clk_cal            (clk_cal),
        .rst_cal_n          (rst_cal_n),
        .nn_layer_cnt       (nn_layer_cnt),
        .omap_addr_span_cnt (omap_addr_span_cnt),
        .wr_addr            (wr_addr),
        .conv_vld           (conv_vld),
        .conv_data          (conv_data),
        .fc_vld             (fc_vld),
        .fc_data            (fc_data),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .out_vld            (out_vld),
        .out_data           (out_data)
    );

    initial clk_cal = 1'b0;
    always #50 clk_cal = ~clk_cal;

    // ************************************************************
    // random numbers and model rules
    // ************************************************************

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic fmap_pkg::lane_vec_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // upper bits of the LCG are the better ones
    function automatic fmap_pkg::fmap_addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return r[31:23];
    endfunction

    function automatic logic is_fc_layer(input fmap_pkg::layer_t layer);
        return (int'(layer) >= `FMAP_FC_FIRST_LAYER) && (int'(layer) <= `FMAP_FC_LAST_LAYER);
    endfunction

    // tail spans of each layer's output map
    function automatic int keep_lanes(input fmap_pkg::layer_t layer, input fmap_pkg::span_t span);
        int keep;
        keep = `FMAP_LANES;
        case (int'(layer))
            1: begin
                if (span == 56) begin
                    keep = 6;
                end else if (span == 57) begin
                    keep = 0;
                end
            end
            2: keep = (span == 14) ? 3 : `FMAP_LANES;
            3: keep = (span == 7) ? 1 : `FMAP_LANES;
            4: keep = (span == 3) ? 4 : `FMAP_LANES;
            5: keep = (span == 1) ? 6 : `FMAP_LANES;
            6: keep = (span == 0) ? 7 : `FMAP_LANES;
            7: keep = 3;
            default: keep = `FMAP_LANES;
        endcase
        return keep;
    endfunction

    function automatic fmap_pkg::lane_vec_t mask_word(input fmap_pkg::lane_vec_t word,
                                                      input int keep);
        fmap_pkg::lane_vec_t res;
        res = word;
        for (int i = keep; i < `FMAP_LANES; i++) begin
            res[i] = '0;
        end
        return res;
    endfunction

    // ************************************************************
    // compare tasks
    // ************************************************************

    task automatic check_word(input fmap_pkg::lane_vec_t got, input fmap_pkg::lane_vec_t exp,
                              input string what);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vld(input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: out_vld got %b expected %b", $time, got, exp);
        end
    endtask

    // ************************************************************
    // stimulus tasks
    // ************************************************************

    // one clock of inputs, the model follows the same rules at the input cycle
    task automatic apply_cycle(input logic cv, input fmap_pkg::lane_vec_t cd,
                               input logic fv, input fmap_pkg::lane_vec_t fd,
                               input fmap_pkg::fmap_addr_t wa,
                               input logic re, input fmap_pkg::fmap_addr_t ra);
        logic                fc_src;
        logic                wr_hit;
        logic                rd_bank_m;
        fmap_pkg::lane_vec_t wd;
        @(posedge clk_cal);
        nn_layer_cnt       <= cur_layer;
        omap_addr_span_cnt <= cur_span;
        wr_addr            <= wa;
        conv_vld           <= cv;
        conv_data          <= cd;
        fc_vld             <= fv;
        fc_data            <= fd;
        rd_en              <= re;
        rd_addr            <= ra;
        fc_src    = is_fc_layer(cur_layer);
        wr_hit    = fc_src ? fv : cv;
        rd_bank_m = ~cur_layer[0];
        if (re) begin
            exp_q.push_back(model_mem[rd_bank_m][ra]);
        end
        if (wr_hit) begin
            wd = mask_word(fc_src ? fd : cd, keep_lanes(cur_layer, cur_span));
            model_mem[cur_layer[0]][wa] = wd;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) apply_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic write_conv(input fmap_pkg::fmap_addr_t addr, input fmap_pkg::lane_vec_t data);
        apply_cycle(1'b1, data, 1'b0, '0, addr, 1'b0, '0);
    endtask

    task automatic write_fc_only(input fmap_pkg::fmap_addr_t addr,
                                 input fmap_pkg::lane_vec_t data);
        apply_cycle(1'b0, '0, 1'b1, data, addr, 1'b0, '0);
    endtask

    // both valids high with different words
    task automatic write_both(input fmap_pkg::fmap_addr_t addr);
        apply_cycle(1'b1, rand_word(), 1'b1, rand_word(), addr, 1'b0, '0);
    endtask

    task automatic read_word(input fmap_pkg::fmap_addr_t addr);
        apply_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, addr);
    endtask

    task automatic read_and_write(input fmap_pkg::fmap_addr_t addr,
                                  input fmap_pkg::lane_vec_t data);
        apply_cycle(1'b1, data, 1'b0, '0, addr, 1'b1, addr);
    endtask

    // gap lets the last write of the old layer land before reads
    task automatic enter_layer(input int layer, input fmap_pkg::span_t span);
        cur_layer = fmap_pkg::layer_t'(layer);
        cur_span  = span;
        idle_cycles(2);
    endtask

    // ************************************************************
    // output monitor and timeout
    // ************************************************************

    // expected out_vld is rd_en delayed by two cycles
    always @(negedge clk_cal) begin
        if (rst_cal_n) begin
            check_vld(out_vld, vld_d2);
            if (vld_d2) begin
                if (exp_q.size() == 0) begin
                    other_err_cnt++;
                    $display("ERROR at %0t ns: read result due but no read was queued", $time);
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_word(out_data, mon_exp, "out_data");
                end
                seen_read = 1'b1;
            end else if (!seen_read) begin
                check_word(out_data, '0, "out_data before first read");
            end
        end
        vld_d2 = vld_d1;
        vld_d1 = rd_en & rst_cal_n;
    end

    always @(posedge clk_cal) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles and was stopped", CYCLE_LIMIT);
            $display("summary: %0d checks, %0d mismatches, %0d other errors",
                     check_cnt, mismatch_cnt, other_err_cnt + 1);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin : stimulus
        fmap_pkg::fmap_addr_t rt_addr [ROUND_TRIP_N];
        fmap_pkg::fmap_addr_t pp_addr [PP_N];
        fmap_pkg::fmap_addr_t fc_addr [FC_N];
        logic [31:0]          r;
        int                   gap;

        rst_cal_n          = 1'b0;
        nn_layer_cnt       = '0;
        omap_addr_span_cnt = '0;
        wr_addr            = '0;
        conv_vld           = 1'b0;
        conv_data          = '0;
        fc_vld             = 1'b0;
        fc_data            = '0;
        rd_en              = 1'b0;
        rd_addr            = '0;
        lcg_state          = 32'd58;
        cur_layer          = '0;
        cur_span           = '0;
        vld_d1             = 1'b0;
        vld_d2             = 1'b0;
        seen_read          = 1'b0;
        check_cnt          = 0;
        mismatch_cnt       = 0;
        other_err_cnt      = 0;
        cycle_cnt          = 0;

        repeat (4) @(posedge clk_cal);
        rst_cal_n <= 1'b1;
        // quiet outputs after reset
        idle_cycles(4);

        // full-lane round trip, layer 0 into bank 0
        for (int i = 0; i < ROUND_TRIP_N; i++) begin
            rt_addr[i] = rand_addr();
            write_conv(rt_addr[i], rand_word());
        end
        enter_layer(1, fmap_pkg::span_t'(0));
        for (int i = 0; i < ROUND_TRIP_N; i++) begin
            read_word(rt_addr[i]);
        end
        for (int i = 0; i < ROUND_TRIP_N; i++) begin
            read_word(rt_addr[ROUND_TRIP_N-1-i]);
            r   = next_rand();
            gap = int'(r[31:28] % 3);
            idle_cycles(gap);
        end

        // tail spans, each read back one layer later
        cur_span = fmap_pkg::span_t'(56);
        write_conv(9'h1f0, rand_word());
        cur_span = fmap_pkg::span_t'(57);
        write_conv(9'h1f1, rand_word());

        enter_layer(2, fmap_pkg::span_t'(0));
        read_word(9'h1f0);
        read_word(9'h1f1);
        cur_span = fmap_pkg::span_t'(14);
        write_conv(9'h1f2, rand_word());
        cur_span = fmap_pkg::span_t'(0);
        for (int i = 0; i < PP_N; i++) begin
            pp_addr[i] = rand_addr() & 9'h0ff;
            write_conv(pp_addr[i], rand_word());
        end

        // ping-pong: layer 2 words stay readable while layer 3 overwrites the other bank
        enter_layer(3, fmap_pkg::span_t'(0));
        read_word(9'h1f2);
        for (int i = 0; i < PP_N; i++) begin
            read_and_write(pp_addr[i], rand_word());
        end
        cur_span = fmap_pkg::span_t'(7);
        write_conv(9'h1f3, rand_word());

        enter_layer(4, fmap_pkg::span_t'(0));
        read_word(9'h1f3);
        for (int i = 0; i < PP_N; i++) begin
            read_word(pp_addr[i]);
        end
        cur_span = fmap_pkg::span_t'(3);
        write_conv(9'h1f4, rand_word());

        enter_layer(5, fmap_pkg::span_t'(1));
        read_word(9'h1f4);
        write_conv(9'h1f5, rand_word());

        enter_layer(6, fmap_pkg::span_t'(0));
        write_conv(9'h1f6, rand_word());
        // this read is still in flight when the layer moves on
        read_word(9'h1f5);

        // layer 7 keeps three lanes at any span, FC valid alone is ignored
        r = next_rand();
        enter_layer(7, fmap_pkg::span_t'(r[31:22]));
        read_word(9'h1f6);
        write_conv(9'h1f7, rand_word());
        write_fc_only(9'h1f7, rand_word());

        // FC layers take fc_data only
        enter_layer(8, fmap_pkg::span_t'(0));
        read_word(9'h1f7);
        for (int i = 0; i < FC_N; i++) begin
            fc_addr[i] = fmap_pkg::fmap_addr_t'(9'h1e0 + i);
            write_both(fc_addr[i]);
        end
        write_conv(fc_addr[0], rand_word());

        enter_layer(9, fmap_pkg::span_t'(0));
        for (int i = 0; i < FC_N; i++) begin
            read_word(fc_addr[i]);
        end
        for (int i = 0; i < FC_N; i++) begin
            write_both(fc_addr[i]);
        end
        write_conv(fc_addr[1], rand_word());

        enter_layer(10, fmap_pkg::span_t'(0));
        for (int i = 0; i < FC_N; i++) begin
            read_word(fc_addr[i]);
        end

        // drain reads still in flight
        while (exp_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(3);

        $display("summary: %0d checks, %0d mismatches, %0d other errors",
                 check_cnt, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* source/fmap_bank.sv */
// one feature-map bank: 512 words of eight lanes, write port and registered read port
`timescale 1ns/1ns
`include "fmap_params.svh"

module fmap_bank (
    input  logic                 clk_cal,
    input  logic                 wr_en,
    input  fmap_pkg::fmap_addr_t wr_addr,
    input  fmap_pkg::lane_vec_t  wr_data,
    input  logic                 rd_en,
    input  fmap_pkg::fmap_addr_t rd_addr,
    output fmap_pkg::lane_vec_t  rd_data
);

    localparam int DEPTH = 1 << `FMAP_ADDR_W;

    fmap_pkg::lane_vec_t mem [0:DEPTH-1];

    // ************************************************************
    // write port
    // ************************************************************

    always_ff @(posedge clk_cal) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ************************************************************
    // read port
    // ************************************************************

    // output latch holds the last word between reads
    always_ff @(posedge clk_cal) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* source/fmap_buffer_top.sv */
// feature-map buffer top: lane-mask stage feeding the ping-pong store
`timescale 1ns/1ns

module fmap_buffer_top (
    input  logic                 clk_cal,
    input  logic                 rst_cal_n,
    input  fmap_pkg::layer_t     nn_layer_cnt,
    input  fmap_pkg::span_t      omap_addr_span_cnt,
    input  fmap_pkg::fmap_addr_t wr_addr,
    input  logic                 conv_vld,
    input  fmap_pkg::lane_vec_t  conv_data,
    input  logic                 fc_vld,
    input  fmap_pkg::lane_vec_t  fc_data,
    input  logic                 rd_en,
    input  fmap_pkg::fmap_addr_t rd_addr,
    output logic                 out_vld,
    output fmap_pkg::lane_vec_t  out_data
);

    // registered write request from the mask stage
    logic                 wr_vld;
    logic                 wr_bank;
    fmap_pkg::fmap_addr_t wr_addr_q;
    fmap_pkg::lane_vec_t  wr_data;

    // reads come from the bank the previous layer filled
    wire                  rd_bank;

    assign rd_bank = ~nn_layer_cnt[0];

    // ************************************************************
    // write path
    // ************************************************************

    fmap_lane_mask u_mask (
        .clk_cal            (clk_cal),
        .rst_cal_n          (rst_cal_n),
        .nn_layer_cnt       (nn_layer_cnt),
        .omap_addr_span_cnt (omap_addr_span_cnt),
        .wr_addr            (wr_addr),
        .conv_vld           (conv_vld),
        .conv_data          (conv_data),
        .fc_vld             (fc_vld),
        .fc_data            (fc_data),
        .wr_vld             (wr_vld),
        .wr_bank            (wr_bank),
        .wr_addr_q          (wr_addr_q),
        .wr_data            (wr_data)
    );

    // ************************************************************
    // storage and read path
    // ************************************************************

    fmap_pingpong u_store (
        .clk_cal   (clk_cal),
        .rst_cal_n (rst_cal_n),
        .wr_vld    (wr_vld),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr_q),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_addr   (rd_addr),
        .out_vld   (out_vld),
        .out_data  (out_data)
    );

endmodule

/* source/fmap_lane_mask.sv */
// write-side stage: source select, tail-lane zeroing and write request register
`timescale 1ns/1ns
`include "fmap_params.svh"

module fmap_lane_mask (
    input  logic                clk_cal,
    input  logic                rst_cal_n,
    input  fmap_pkg::layer_t    nn_layer_cnt,
    input  fmap_pkg::span_t     omap_addr_span_cnt,
    input  fmap_pkg::fmap_addr_t wr_addr,
    input  logic                conv_vld,
    input  fmap_pkg::lane_vec_t conv_data,
    input  logic                fc_vld,
    input  fmap_pkg::lane_vec_t fc_data,
    output logic                wr_vld,
    output logic                wr_bank,
    output fmap_pkg::fmap_addr_t wr_addr_q,
    output fmap_pkg::lane_vec_t wr_data
);

    // enough bits to count 0..FMAP_LANES kept lanes
    localparam int KEEP_W = $clog2(`FMAP_LANES + 1);

    fmap_pkg::fmap_src_e src_sel;
    logic                sel_vld;
    fmap_pkg::lane_vec_t sel_data;
    fmap_pkg::lane_vec_t masked_data;
    logic [KEEP_W-1:0]   keep_cnt;

    // ************************************************************
    // write source
    // ************************************************************

    // FC layers take the FC engine, everything else the conv/pool path
    always_comb begin
        if (nn_layer_cnt >= fmap_pkg::layer_t'(`FMAP_FC_FIRST_LAYER) &&
            nn_layer_cnt <= fmap_pkg::layer_t'(`FMAP_FC_LAST_LAYER)) begin
            src_sel = fmap_pkg::src_fc;
        end else begin
            src_sel = fmap_pkg::src_conv;
        end
    end

    always_comb begin
        case (src_sel)
            fmap_pkg::src_fc: begin
                sel_vld  = fc_vld;
                sel_data = fc_data;
            end
            default: begin
                sel_vld  = conv_vld;
                sel_data = conv_data;
            end
        endcase
    end

    // ************************************************************
    // tail span lane count
    // ************************************************************

    // last spans of a map only partly fill the word
    always_comb begin
        keep_cnt = KEEP_W'(`FMAP_LANES);
        case (nn_layer_cnt)
            fmap_pkg::layer_t'(1): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(56)) begin
                    keep_cnt = KEEP_W'(6);
                end else if (omap_addr_span_cnt == fmap_pkg::span_t'(57)) begin
                    keep_cnt = KEEP_W'(0);
                end
            end
            fmap_pkg::layer_t'(2): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(14)) keep_cnt = KEEP_W'(3);
            end
            fmap_pkg::layer_t'(3): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(7)) keep_cnt = KEEP_W'(1);
            end
            fmap_pkg::layer_t'(4): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(3)) keep_cnt = KEEP_W'(4);
            end
            fmap_pkg::layer_t'(5): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(1)) keep_cnt = KEEP_W'(6);
            end
            fmap_pkg::layer_t'(6): begin
                if (omap_addr_span_cnt == fmap_pkg::span_t'(0)) keep_cnt = KEEP_W'(7);
            end
            // layer 7 output is three channels wide throughout
            fmap_pkg::layer_t'(7): keep_cnt = KEEP_W'(3);
            default: keep_cnt = KEEP_W'(`FMAP_LANES);
        endcase
    end

    always_comb begin
        for (int i = 0; i < `FMAP_LANES; i++) begin
            masked_data[i] = (i < int'(keep_cnt)) ? sel_data[i] : '0;
        end
    end

    // ************************************************************
    // write request register
    // ************************************************************

    always_ff @(posedge clk_cal or negedge rst_cal_n) begin
        if (!rst_cal_n) begin
            wr_vld <= 1'b0;
        end else begin
            wr_vld <= sel_vld;
        end
    end

    // even layers fill bank 0, odd layers bank 1
    always_ff @(posedge clk_cal) begin
        if (sel_vld) begin
            wr_bank   <= nn_layer_cnt[0];
            wr_addr_q <= wr_addr;
            wr_data   <= masked_data;
        end
    end

endmodule

/* source/fmap_params.svh */
// feature-map buffer widths, lane count and FC layer range
`ifndef FMAP_PARAMS_SVH
`define FMAP_PARAMS_SVH

// ************************************************************
// data path widths
// ************************************************************

// bits per lane sample
`define FMAP_LANE_W         8
// lanes per stored word
`define FMAP_LANES          8
// word address bits, 512 words per bank
`define FMAP_ADDR_W         9

// ************************************************************
// layer control
// ************************************************************

`define FMAP_LAYER_W        4
// output map address span counter
`define FMAP_SPAN_W         10

// layers whose output comes from the FC engine
`define FMAP_FC_FIRST_LAYER 8
`define FMAP_FC_LAST_LAYER  9

`endif

/* source/fmap_pingpong.sv */
// ping-pong store: two banks, parity steering of writes and reads, output register stage
`timescale 1ns/1ns

module fmap_pingpong (
    input  logic                 clk_cal,
    input  logic                 rst_cal_n,
    input  logic                 wr_vld,
    input  logic                 wr_bank,
    input  fmap_pkg::fmap_addr_t wr_addr,
    input  fmap_pkg::lane_vec_t  wr_data,
    input  logic                 rd_en,
    input  logic                 rd_bank,
    input  fmap_pkg::fmap_addr_t rd_addr,
    output logic                 out_vld,
    output fmap_pkg::lane_vec_t  out_data
);

    logic                wr_en0;
    logic                wr_en1;
    logic                rd_en0;
    logic                rd_en1;
    fmap_pkg::lane_vec_t rd_data0;
    fmap_pkg::lane_vec_t rd_data1;

    // first stage of the read pipe, lines up with bank output
    logic                rd_vld_s1;
    logic                rd_bank_s1;

    // ************************************************************
    // bank steering
    // ************************************************************

    assign wr_en0 = wr_vld & ~wr_bank;
    assign wr_en1 = wr_vld & wr_bank;
    assign rd_en0 = rd_en & ~rd_bank;
    assign rd_en1 = rd_en & rd_bank;

    fmap_bank u_bank0 (
        .clk_cal (clk_cal),
        .wr_en   (wr_en0),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en0),
        .rd_addr (rd_addr),
        .rd_data (rd_data0)
    );

    fmap_bank u_bank1 (
        .clk_cal (clk_cal),
        .wr_en   (wr_en1),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en1),
        .rd_addr (rd_addr),
        .rd_data (rd_data1)
    );

    // ************************************************************
    // read pipe
    // ************************************************************

    always_ff @(posedge clk_cal or negedge rst_cal_n) begin
        if (!rst_cal_n) begin
            rd_vld_s1 <= 1'b0;
        end else begin
            rd_vld_s1 <= rd_en;
        end
    end

    // bank travels with the request, so a layer change mid-read is harmless
    always_ff @(posedge clk_cal) begin
        if (rd_en) begin
            rd_bank_s1 <= rd_bank;
        end
    end

    // second stage: pick the answering bank and register it
    always_ff @(posedge clk_cal or negedge rst_cal_n) begin
        if (!rst_cal_n) begin
            out_vld  <= 1'b0;
            out_data <= '0;
        end else begin
            out_vld <= rd_vld_s1;
            if (rd_vld_s1) begin
                out_data <= rd_bank_s1 ? rd_data1 : rd_data0;
            end
        end
    end

endmodule

/* source/fmap_pkg.sv */
// feature-map buffer types: lane, word, address, layer, span and write source
`include "fmap_params.svh"

package fmap_pkg;

    // ************************************************************
    // data types
    // ************************************************************

    // one signed activation sample
    typedef logic signed [`FMAP_LANE_W-1:0] lane_data_t;

    // one word, lane 0 in the low byte
    typedef lane_data_t [`FMAP_LANES-1:0] lane_vec_t;

    typedef logic [`FMAP_ADDR_W-1:0] fmap_addr_t;

    // ************************************************************
    // control types
    // ************************************************************

    typedef logic [`FMAP_LAYER_W-1:0] layer_t;

    typedef logic [`FMAP_SPAN_W-1:0] span_t;

    // where the layer output comes from
    typedef enum logic {
        src_conv,
        src_fc
    } fmap_src_e;

endpackage
